// File: hw/ex_pkg.sv
/*
  Shared definitions for the execute stage and its testbench.
  Holds the data and register address widths, the ALU and multiplier
  operator codes, the request and write port structs, and the
  multiplier state encoding. Compile this file before any RTL file.
*/

package ex_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned XLEN       = 32;
  // Integer register file only, 32 entries
  localparam int unsigned REG_ADDR_W = 5;

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  //////////////////////////////////////////////////////////////////////
  // Operator codes
  //////////////////////////////////////////////////////////////////////

  typedef logic [3:0] alu_op_t;

  // Arithmetic and logic
  localparam alu_op_t ALU_ADD = 4'd0;
  localparam alu_op_t ALU_SUB = 4'd1;
  localparam alu_op_t ALU_AND = 4'd2;
  localparam alu_op_t ALU_OR  = 4'd3;
  localparam alu_op_t ALU_XOR = 4'd4;
  // Shifts by b[4:0]
  localparam alu_op_t ALU_SLL = 4'd5;
  localparam alu_op_t ALU_SRL = 4'd6;
  localparam alu_op_t ALU_SRA = 4'd7;
  // Comparisons, also the branch conditions
  localparam alu_op_t ALU_EQ  = 4'd8;
  localparam alu_op_t ALU_NE  = 4'd9;
  localparam alu_op_t ALU_LT  = 4'd10;
  localparam alu_op_t ALU_GE  = 4'd11;
  localparam alu_op_t ALU_LTU = 4'd12;
  localparam alu_op_t ALU_GEU = 4'd13;

  typedef logic [1:0] mult_op_t;

  localparam mult_op_t MUL_LO  = 2'd0;
  localparam mult_op_t MUL_MAC = 2'd1;
  // High word variants take two cycles
  localparam mult_op_t MUL_HS  = 2'd2;
  localparam mult_op_t MUL_HU  = 2'd3;

  //////////////////////////////////////////////////////////////////////
  // Structs and state encoding
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    alu_op_t op;
    word_t   a;
    word_t   b;
    word_t   c;
  } alu_req_t;

  typedef struct packed {
    mult_op_t op;
    word_t    a;
    word_t    b;
    word_t    c;
  } mult_req_t;

  // Register file write port, used for forwarding and for load data
  typedef struct packed {
    logic      we;
    reg_addr_t waddr;
    word_t     wdata;
  } wb_port_t;

  typedef enum logic {
    MULT_IDLE = 1'b0,
    MULT_HIGH = 1'b1
  } mult_state_e;

endpackage

// File: hw/ex_alu.sv
/*
  Integer ALU of the execute stage.
  Purely combinational. Computes add, subtract, logic, shift and compare
  operations on operands a and b. The compare bit doubles as the branch
  decision, and compare operations return it zero extended as result.
*/

`timescale 1ns/1ps

module ex_alu (
  input  ex_pkg::alu_req_t req_i,
  output ex_pkg::word_t    result_o,
  output logic             cmp_o
);

  import ex_pkg::*;

  // Shift amount from the low bits of operand b
  logic [4:0] shamt;

  // Shared comparison terms
  logic       eq;
  logic       lt_s;
  logic       lt_u;

  word_t      sum;
  word_t      diff;

  assign shamt = req_i.b[4:0];

  assign sum   = req_i.a + req_i.b;
  assign diff  = req_i.a - req_i.b;

  assign eq    = (req_i.a == req_i.b);
  assign lt_s  = ($signed(req_i.a) < $signed(req_i.b));
  assign lt_u  = (req_i.a < req_i.b);

  //////////////////////////////////////////////////////////////////////
  // Comparison
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (req_i.op)
      ALU_EQ:  cmp_o = eq;
      ALU_NE:  cmp_o = ~eq;
      ALU_LT:  cmp_o = lt_s;
      ALU_GE:  cmp_o = ~lt_s;
      ALU_LTU: cmp_o = lt_u;
      ALU_GEU: cmp_o = ~lt_u;
      // Arithmetic, logic and shifts never take a branch
      default: cmp_o = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Result select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    result_o = '0;
    case (req_i.op)
      ALU_ADD: result_o = sum;
      ALU_SUB: result_o = diff;
      ALU_AND: result_o = req_i.a & req_i.b;
      ALU_OR:  result_o = req_i.a | req_i.b;
      ALU_XOR: result_o = req_i.a ^ req_i.b;
      ALU_SLL: result_o = req_i.a << shamt;
      ALU_SRL: result_o = req_i.a >> shamt;
      // Arithmetic shift keeps the sign bit
      ALU_SRA: result_o = word_t'($signed(req_i.a) >>> shamt);
      ALU_EQ,
      ALU_NE,
      ALU_LT,
      ALU_GE,
      ALU_LTU,
      ALU_GEU: result_o = {{(XLEN-1){1'b0}}, cmp_o};
      // Unused codes give zero
      default: result_o = '0;
    endcase
  end

endmodule

// File: hw/ex_mult.sv
/*
  Integer multiplier of the execute stage.
  Low word multiply and multiply-accumulate finish in the same cycle.
  Signed and unsigned high word multiplies register the upper half of
  the 64-bit product and hold ready low for one cycle, then present the
  stored word with multicycle_o high until the stage moves on.
*/

`timescale 1ns/1ps

module ex_mult (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              en_i,
  input  ex_pkg::mult_req_t req_i,
  input  logic              ex_ready_i,
  output ex_pkg::word_t     result_o,
  output logic              ready_o,
  output logic              multicycle_o
);

  import ex_pkg::*;

  mult_state_e         state_q;
  mult_state_e         state_d;

  // Stored upper word of the product
  word_t               hi_q;

  logic                is_high;
  logic                ext_a;
  logic                ext_b;
  logic [2*XLEN-1:0]   product;
  word_t               mac_sum;

  assign is_high = (req_i.op == MUL_HS) || (req_i.op == MUL_HU);

  // Sign extension only for the signed high word
  assign ext_a   = (req_i.op == MUL_HS) & req_i.a[XLEN-1];
  assign ext_b   = (req_i.op == MUL_HS) & req_i.b[XLEN-1];

  // One 64-bit product serves all variants since the low half is sign agnostic
  assign product = {{XLEN{ext_a}}, req_i.a} * {{XLEN{ext_b}}, req_i.b};
  assign mac_sum = product[XLEN-1:0] + req_i.c;

  //////////////////////////////////////////////////////////////////////
  // High word FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      MULT_IDLE: begin
        // Start the second cycle regardless of ex_ready
        if (en_i && is_high) begin
          state_d = MULT_HIGH;
        end
      end
      MULT_HIGH: begin
        // Hold the stored word while writeback stalls
        if (ex_ready_i) begin
          state_d = MULT_IDLE;
        end
      end
      default: state_d = MULT_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MULT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Capture the upper word on the first cycle only
  always_ff @(posedge clk) begin
    if (state_q == MULT_IDLE && en_i && is_high) begin
      hi_q <= product[2*XLEN-1:XLEN];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (state_q == MULT_HIGH) begin
      result_o = hi_q;
    end else begin
      case (req_i.op)
        MUL_LO:  result_o = product[XLEN-1:0];
        MUL_MAC: result_o = mac_sum;
        default: result_o = product[2*XLEN-1:XLEN];
      endcase
    end
  end

  // Stall only in the first cycle of a high word multiply
  assign ready_o      = ~((state_q == MULT_IDLE) & en_i & is_high);
  assign multicycle_o = (state_q == MULT_HIGH);

endmodule

// File: hw/ex_wb_ports.sv
/*
  Write ports of the execute stage.
  The forwarding port picks CSR data, multiplier or ALU result by
  priority and goes straight to the register file and ID bypass.
  The EX/WB register tracks the load destination, and the load port
  combines it with the LSU read data one cycle later.
*/

`timescale 1ns/1ps

module ex_wb_ports (
  input  logic              clk,
  input  logic              rst_n,
  input  ex_pkg::word_t     alu_result_i,
  input  ex_pkg::word_t     mult_result_i,
  input  logic              mult_en_i,
  input  logic              csr_access_i,
  input  ex_pkg::word_t     csr_rdata_i,
  input  logic              alu_we_i,
  input  ex_pkg::reg_addr_t alu_waddr_i,
  input  logic              we_i,
  input  ex_pkg::reg_addr_t waddr_i,
  input  logic              lsu_err_i,
  input  ex_pkg::word_t     lsu_rdata_i,
  input  logic              ex_valid_i,
  input  logic              wb_ready_i,
  output ex_pkg::wb_port_t  fw_port_o,
  output ex_pkg::wb_port_t  wb_port_o
);

  import ex_pkg::*;

  // EX/WB register contents
  logic      lsu_we_q;
  reg_addr_t lsu_waddr_q;

  // Load writes only when no bus error came back
  logic      lsu_we_d;

  assign lsu_we_d = we_i & ~lsu_err_i;

  //////////////////////////////////////////////////////////////////////
  // Forwarding port
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    fw_port_o.we    = alu_we_i;
    fw_port_o.waddr = alu_waddr_i;
    // CSR first, then multiplier, then ALU
    if (csr_access_i) begin
      fw_port_o.wdata = csr_rdata_i;
    end else if (mult_en_i) begin
      fw_port_o.wdata = mult_result_i;
    end else begin
      fw_port_o.wdata = alu_result_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // EX/WB register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lsu_we_q    <= 1'b0;
      lsu_waddr_q <= '0;
    end else if (ex_valid_i) begin
      // ex_valid already includes wb_ready
      lsu_we_q <= lsu_we_d;
      if (lsu_we_d) begin
        lsu_waddr_q <= waddr_i;
      end
    end else if (wb_ready_i) begin
      // Nothing new arrives, so the old entry drains out
      lsu_we_q <= 1'b0;
    end
  end

  // Load data arrives from the LSU in the WB cycle
  assign wb_port_o.we    = lsu_we_q;
  assign wb_port_o.waddr = lsu_waddr_q;
  assign wb_port_o.wdata = lsu_rdata_i;

endmodule

// File: hw/ex_stage.sv
/*
  Execute stage top level.
  Connects the ALU, the multiplier and the write ports, and forms the
  stage ready and valid levels from the unit and writeback readiness.
  Branch decision and jump target leave here for the fetch stage.
*/

`timescale 1ns/1ps

module ex_stage (
  input  logic              clk,
  input  logic              rst_n,

  // ALU request from ID
  input  ex_pkg::alu_req_t  alu_req_i,
  input  logic              alu_en_i,

  // Multiplier request from ID
  input  ex_pkg::mult_req_t mult_req_i,
  input  logic              mult_en_i,

  // CSR read data
  input  logic              csr_access_i,
  input  ex_pkg::word_t     csr_rdata_i,

  // Load/store unit
  input  logic              lsu_en_i,
  input  ex_pkg::word_t     lsu_rdata_i,
  input  logic              lsu_ready_ex_i,
  input  logic              lsu_err_i,

  input  logic              branch_in_ex_i,

  // Forwarding and load destinations
  input  logic              regfile_alu_we_i,
  input  ex_pkg::reg_addr_t regfile_alu_waddr_i,
  input  logic              regfile_we_i,
  input  ex_pkg::reg_addr_t regfile_waddr_i,

  input  logic              wb_ready_i,

  output ex_pkg::wb_port_t  fw_port_o,
  output ex_pkg::wb_port_t  wb_port_o,
  output logic              branch_decision_o,
  output ex_pkg::word_t     jump_target_o,
  output logic              mult_multicycle_o,
  output logic              ex_ready_o,
  output logic              ex_valid_o
);

  import ex_pkg::*;

  word_t alu_result;
  logic  alu_cmp;
  word_t mult_result;
  logic  mult_ready;

  //////////////////////////////////////////////////////////////////////
  // Units
  //////////////////////////////////////////////////////////////////////

  ex_alu i_ex_alu (
    .req_i    (alu_req_i),
    .result_o (alu_result),
    .cmp_o    (alu_cmp)
  );

  ex_mult i_ex_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .en_i         (mult_en_i),
    .req_i        (mult_req_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  ex_wb_ports i_ex_wb_ports (
    .clk           (clk),
    .rst_n         (rst_n),
    .alu_result_i  (alu_result),
    .mult_result_i (mult_result),
    .mult_en_i     (mult_en_i),
    .csr_access_i  (csr_access_i),
    .csr_rdata_i   (csr_rdata_i),
    .alu_we_i      (regfile_alu_we_i),
    .alu_waddr_i   (regfile_alu_waddr_i),
    .we_i          (regfile_we_i),
    .waddr_i       (regfile_waddr_i),
    .lsu_err_i     (lsu_err_i),
    .lsu_rdata_i   (lsu_rdata_i),
    .ex_valid_i    (ex_valid_o),
    .wb_ready_i    (wb_ready_i),
    .fw_port_o     (fw_port_o),
    .wb_port_o     (wb_port_o)
  );

  // Branches resolve here and need no writeback slot
  assign branch_decision_o = alu_cmp;
  assign jump_target_o     = alu_req_i.c;

  // Ready flows back to ID, valid flows on to WB
  assign ex_ready_o = (mult_ready & lsu_ready_ex_i & wb_ready_i) | branch_in_ex_i;
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i)
                      & mult_ready & lsu_ready_ex_i & wb_ready_i;

endmodule

// File: dv/ex_stage_asserts.sv
/*
  Concurrent assertions on the execute stage, bound to the top level.
  Covers the EX/WB register under reset, the high word multiply stall
  and the hold rule of the EX/WB register under writeback back-pressure.
*/

`timescale 1ns/1ps

module ex_stage_asserts (
  input logic             clk,
  input logic             rst_n,
  input logic             mult_en_i,
  input ex_pkg::mult_op_t mult_op_i,
  input logic             multicycle_i,
  input logic             branch_i,
  input logic             ex_ready_i,
  input logic             ex_valid_i,
  input logic             wb_ready_i,
  input ex_pkg::wb_port_t wb_port_i
);

  // Load port stays silent in reset
  a_reset_no_we: assert property (@(posedge clk) !rst_n |-> !wb_port_i.we)
    else $error("load port write enable high during reset");

  // High word multiply stalls, then enters its second cycle
  a_high_stall: assert property (@(posedge clk) disable iff (!rst_n)
    (mult_en_i && mult_op_i[1] && !multicycle_i && !branch_i)
      |-> !ex_ready_i ##1 multicycle_i)
    else $error("high word multiply did not stall for one cycle");

  // Back-pressure with nothing new keeps the EX/WB register
  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (!wb_ready_i && !ex_valid_i) |=> ($stable(wb_port_i.we) && $stable(wb_port_i.waddr)))
    else $error("EX/WB register changed under back-pressure");

endmodule

bind ex_stage ex_stage_asserts i_ex_stage_asserts (
  .clk          (clk),
  .rst_n        (rst_n),
  .mult_en_i    (mult_en_i),
  .mult_op_i    (mult_req_i.op),
  .multicycle_i (mult_multicycle_o),
  .branch_i     (branch_in_ex_i),
  .ex_ready_i   (ex_ready_o),
  .ex_valid_i   (ex_valid_o),
  .wb_ready_i   (wb_ready_i),
  .wb_port_i    (wb_port_o)
);

// File: dv/ex_stage_tb.sv
/*
  Testbench for the execute stage.
  Reads one test per line from the stim file, drives the DUT through ALU,
  branch, multiply, forwarding, load and back-pressure sequences, and
  compares the responses with the expected values of each line.
  Inputs change on the rising edge and outputs are sampled on the falling edge.
*/

`timescale 1ns/1ps

module ex_stage_tb;

  import ex_pkg::*;

  localparam int MAX_TESTS = 64;

  logic      clk;
  logic      rst_n;
  alu_req_t  alu_req_i;
  logic      alu_en_i;
  mult_req_t mult_req_i;
  logic      mult_en_i;
  logic      csr_access_i;
  word_t     csr_rdata_i;
  logic      lsu_en_i;
  word_t     lsu_rdata_i;
  logic      lsu_ready_ex_i;
  logic      lsu_err_i;
  logic      branch_in_ex_i;
  logic      regfile_alu_we_i;
  reg_addr_t regfile_alu_waddr_i;
  logic      regfile_we_i;
  reg_addr_t regfile_waddr_i;
  logic      wb_ready_i;
  wb_port_t  fw_port_o;
  wb_port_t  wb_port_o;
  logic      branch_decision_o;
  word_t     jump_target_o;
  logic      mult_multicycle_o;
  logic      ex_ready_o;
  logic      ex_valid_o;

  // Test table loaded from the stim file
  string       t_name [MAX_TESTS];
  string       t_kind [MAX_TESTS];
  logic [31:0] t_op   [MAX_TESTS];
  logic [31:0] t_a    [MAX_TESTS];
  logic [31:0] t_b    [MAX_TESTS];
  logic [31:0] t_c    [MAX_TESTS];
  logic [31:0] t_aux  [MAX_TESTS];
  logic [31:0] t_exp  [MAX_TESTS];
  logic [31:0] t_bit  [MAX_TESTS];
  int          n_tests;
  int          err_count;
  logic [31:0] lfsr;

  ex_stage i_ex_stage (.*);

  always #2 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Random fill
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic rand_word(output word_t w);
    for (int i = 0; i < XLEN; i++) begin
      lfsr = lfsr_step(lfsr);
      w[i] = lfsr[0];
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("Fail %s: expected %b, actual %b", name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_port(input string name, input wb_port_t exp, input wb_port_t act);
    if (exp !== act) begin
      $display("Fail %s: expected %h/%h/%h, actual %h/%h/%h", name,
               exp.we, exp.waddr, exp.wdata, act.we, act.waddr, act.wdata);
      err_count++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sequences
  //////////////////////////////////////////////////////////////////////

  // Return all enables to idle with writeback ready
  task automatic go_idle();
    @(posedge clk);
    alu_en_i       <= 1'b0;
    mult_en_i      <= 1'b0;
    csr_access_i   <= 1'b0;
    lsu_en_i       <= 1'b0;
    regfile_we_i   <= 1'b0;
    lsu_err_i      <= 1'b0;
    branch_in_ex_i <= 1'b0;
    wb_ready_i     <= 1'b1;
  endtask

  // Load into the EX/WB register so the entry shows after the next edge
  task automatic start_load(input int k);
    @(posedge clk);
    lsu_en_i        <= 1'b1;
    regfile_we_i    <= 1'b1;
    regfile_waddr_i <= t_aux[k][4:0];
    lsu_err_i       <= t_op[k][0];
    lsu_rdata_i     <= t_a[k];
    @(posedge clk);
    lsu_en_i        <= 1'b0;
    regfile_we_i    <= 1'b0;
    lsu_err_i       <= 1'b0;
  endtask

  task automatic run_test(input int k);
    word_t    fill;
    wb_port_t exp_port;
    rand_word(fill);
    case (t_kind[k])
      "alu", "branch": begin
        @(posedge clk);
        alu_en_i            <= 1'b1;
        alu_req_i           <= '{op: t_op[k][3:0], a: t_a[k], b: t_b[k],
                                 c: (t_kind[k] == "branch") ? t_c[k] : fill};
        regfile_alu_we_i    <= t_bit[k][0];
        regfile_alu_waddr_i <= t_aux[k][4:0];
        if (t_kind[k] == "branch") begin
          branch_in_ex_i <= 1'b1;
          wb_ready_i     <= 1'b0;
        end
        @(negedge clk);
        if (t_kind[k] == "alu") begin
          check_port(t_name[k], '{we: t_bit[k][0], waddr: t_aux[k][4:0], wdata: t_exp[k]},
                     fw_port_o);
        end else begin
          check_bit(t_name[k], t_bit[k][0], branch_decision_o);
          check_word(t_name[k], t_exp[k], jump_target_o);
          check_bit(t_name[k], 1'b1, ex_ready_o);
        end
      end
      "mult": begin
        @(posedge clk);
        mult_en_i  <= 1'b1;
        mult_req_i <= '{op: t_op[k][1:0], a: t_a[k], b: t_b[k],
                        c: (t_op[k][1:0] == MUL_MAC) ? t_c[k] : fill};
        @(negedge clk);
        if (t_op[k][1]) begin
          // High word stalls one cycle, then shows the stored word
          check_bit(t_name[k], 1'b0, ex_ready_o);
          @(negedge clk);
          check_bit(t_name[k], 1'b1, mult_multicycle_o);
        end
        check_bit(t_name[k], 1'b1, ex_ready_o);
        check_word(t_name[k], t_exp[k], fw_port_o.wdata);
        go_idle();
        @(negedge clk);
        check_bit(t_name[k], 1'b0, mult_multicycle_o);
      end
      "csr": begin
        @(posedge clk);
        csr_access_i <= t_op[k][2];
        mult_en_i    <= t_op[k][1];
        alu_en_i     <= t_op[k][0];
        csr_rdata_i  <= t_a[k];
        alu_req_i    <= '{op: ALU_ADD, a: t_b[k], b: '0, c: fill};
        mult_req_i   <= '{op: MUL_LO, a: t_c[k], b: 32'd1, c: fill};
        @(negedge clk);
        check_word(t_name[k], t_exp[k], fw_port_o.wdata);
      end
      "lsu": begin
        start_load(k);
        @(negedge clk);
        if (t_bit[k][0]) begin
          check_port(t_name[k], '{we: 1'b1, waddr: t_aux[k][4:0], wdata: t_exp[k]},
                     wb_port_o);
        end else begin
          check_bit(t_name[k], 1'b0, wb_port_o.we);
          check_word(t_name[k], t_exp[k], wb_port_o.wdata);
        end
      end
      "bp": begin
        exp_port = '{we: 1'b1, waddr: t_aux[k][4:0], wdata: t_exp[k]};
        start_load(k);
        wb_ready_i <= 1'b0;
        alu_en_i   <= 1'b1;
        @(negedge clk);
        check_bit(t_name[k], 1'b0, ex_ready_o);
        check_bit(t_name[k], 1'b0, ex_valid_o);
        check_port(t_name[k], exp_port, wb_port_o);
        @(negedge clk);
        check_port(t_name[k], exp_port, wb_port_o);
        @(posedge clk);
        wb_ready_i <= 1'b1;
        alu_en_i   <= 1'b0;
        @(negedge clk);
        check_bit(t_name[k], 1'b1, wb_port_o.we);
        @(negedge clk);
        check_bit(t_name[k], 1'b0, wb_port_o.we);
      end
      default: begin
        $display("Unknown test kind %s in test %s", t_kind[k], t_name[k]);
        err_count++;
      end
    endcase
    go_idle();
  endtask

  task automatic load_stim();
    int    fd;
    int    cnt;
    string line;
    fd = $fopen("dv/ex_stim.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stim file");
      err_count++;
    end else begin
      while (!$feof(fd) && n_tests < MAX_TESTS) begin
        line = "";
        cnt  = $fgets(line, fd);
        // Comment and blank lines do not give all nine fields
        cnt  = $sscanf(line, "%s %s %h %h %h %h %h %h %h", t_name[n_tests],
                       t_kind[n_tests], t_op[n_tests], t_a[n_tests], t_b[n_tests],
                       t_c[n_tests], t_aux[n_tests], t_exp[n_tests], t_bit[n_tests]);
        if (cnt == 9) begin
          n_tests++;
        end
      end
      $fclose(fd);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main flow and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    int errs_before;
    clk = 1'b0;
    rst_n = 1'b0;
    alu_req_i = '0;
    alu_en_i = 1'b0;
    mult_req_i = '0;
    mult_en_i = 1'b0;
    csr_access_i = 1'b0;
    csr_rdata_i = '0;
    lsu_en_i = 1'b0;
    lsu_rdata_i = '0;
    lsu_ready_ex_i = 1'b1;
    lsu_err_i = 1'b0;
    branch_in_ex_i = 1'b0;
    regfile_alu_we_i = 1'b0;
    regfile_alu_waddr_i = '0;
    regfile_we_i = 1'b0;
    regfile_waddr_i = '0;
    wb_ready_i = 1'b1;
    n_tests = 0;
    err_count = 0;
    lfsr = 32'h77b4;
    load_stim();
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    for (int k = 0; k < n_tests; k++) begin
      errs_before = err_count;
      run_test(k);
      $display("Test %s: %s", t_name[k], (err_count == errs_before) ? "ok" : "failed");
    end
    $display("Tests run: %0d, errors: %0d", n_tests, err_count);
    if (err_count == 0 && n_tests > 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Twenty cycles of 4 ns per test, plus reset
  initial begin
    #1;
    #((n_tests * 20 + 20) * 4);
    $display("Timeout: the tests did not finish in time");
    $display("Done: errors found");
    $finish;
  end

endmodule

// File: dv/ex_stim.txt
# name kind op a b c aux exp_word exp_bit (all numbers hex)
# alu: aux=waddr, exp_bit=we; branch: c=target, exp_bit=decision
# mult: op=mult code; csr: op=enables csr,mult,alu, a=csr b=alu c=mult
# lsu/bp: op=err, a=rdata, aux=waddr, exp_bit=expected we
add       alu    0 00000005 00000003 0 01 00000008 1
add_wrap  alu    0 ffffffff 00000002 0 02 00000001 1
sub       alu    1 00000003 00000005 0 03 fffffffe 1
and       alu    2 f0f0f0f0 ff00ff00 0 04 f000f000 1
or        alu    3 f0f0f0f0 0f0f0000 0 05 fffff0f0 1
xor       alu    4 aaaa5555 ffff0000 0 06 55555555 1
sll       alu    5 00000001 00000024 0 07 00000010 1
srl       alu    6 80000000 0000001f 0 08 00000001 1
sra       alu    7 80000000 00000004 0 09 f8000000 1
slt_res   alu    a ffffffff 00000001 0 0a 00000001 1
sltu_res  alu    c ffffffff 00000001 0 0b 00000000 1
add_nowe  alu    0 00000010 00000020 0 0c 00000030 0
beq_t     branch 8 00000007 00000007 00001000 0 00001000 1
beq_n     branch 8 00000007 00000008 00001004 0 00001004 0
bne       branch 9 00000007 00000008 00002000 0 00002000 1
blt       branch a 80000000 00000001 00003000 0 00003000 1
bge       branch b 80000000 00000001 00004000 0 00004000 0
bltu      branch c 80000000 00000001 00005000 0 00005000 0
bgeu      branch d 80000000 00000001 00006000 0 00006000 1
mul_lo    mult   0 00000006 00000007 0 0 0000002a 0
mul_neg   mult   0 ffffffff 00000003 0 0 fffffffd 0
mac       mult   1 00000010 00000010 00000005 0 00000105 0
mulh_neg  mult   2 80000000 00000002 0 0 ffffffff 0
mulh_pos  mult   2 00010000 00010000 0 0 00000001 0
mulhu_max mult   3 ffffffff ffffffff 0 0 fffffffe 0
mulhu_bit mult   3 80000000 00000002 0 0 00000001 0
csr_all   csr    7 11111111 22222222 33333333 0 11111111 0
csr_only  csr    4 11111111 22222222 33333333 0 11111111 0
mult_alu  csr    3 11111111 22222222 33333333 0 33333333 0
alu_only  csr    1 11111111 22222222 33333333 0 22222222 0
mult_only csr    2 11111111 22222222 33333333 0 33333333 0
csr_alu   csr    5 11111111 22222222 33333333 0 11111111 0
ld_ok     lsu    0 deadbeef 0 0 0a deadbeef 1
ld_ok2    lsu    0 12345678 0 0 1f 12345678 1
ld_err    lsu    1 cafef00d 0 0 05 cafef00d 0
bp_hold   bp     0 0badcafe 0 0 0c 0badcafe 1
bp_hold2  bp     0 00c0ffee 0 0 03 00c0ffee 1

// File: all.f
hw/ex_pkg.sv
hw/ex_alu.sv
hw/ex_mult.sv
hw/ex_wb_ports.sv
hw/ex_stage.sv
dv/ex_stage_asserts.sv
dv/ex_stage_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module ex_stage_tb \
  -f all.f \
  --Mdir obj_dir -o ex_sim

./obj_dir/ex_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Done: no errors" sim.log; then
  exit 0
else
  exit 1
fi
